/* sources.f */
verilog/ledgame_pkg.sv
verilog/button_debounce.sv
verilog/game_cfg_regs.sv
verilog/piece_field.sv
verilog/max7219_driver.sv
verilog/ledgame_top.sv
testbench/max7219_monitor.sv
testbench/ledgame_tb.sv

/* Bender.yml */
package:
  name: ledgame

sources:
  - verilog/ledgame_pkg.sv
  - verilog/button_debounce.sv
  - verilog/game_cfg_regs.sv
  - verilog/piece_field.sv
  - verilog/max7219_driver.sv
  - verilog/ledgame_top.sv
  - target: simulation
    files:
      - testbench/max7219_monitor.sv
      - testbench/ledgame_tb.sv

/* testbench/ledgame_tb.sv */
/*
 * Testbench for ledgame_top with debounce 4 and clk_div 2. Each table step
 * is followed by a status read and a check of the decoded digit images.
 */
`timescale 1ns/1ps

module ledgame_tb;

	typedef enum logic [2:0] {act_start, act_left, act_right, act_write, act_land} action_t;

	// Write argument holds the address in bits 17:16
	typedef struct packed {
		action_t     act;
		logic [17:0] arg;
		logic [1:0]  st;
		logic [2:0]  row;
		logic [2:0]  col;
	} step_t;

	localparam int debounce  = 4;
	localparam int num_steps = 9;

	logic        clock_50;
	logic        rst_n;
	logic        start_button_n;
	logic        left_button_n;
	logic        right_button_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [1:0]  wb_adr;
	logic [15:0] wb_dat_w;
	logic [15:0] wb_dat_r;
	logic        wb_ack;
	logic        max_din;
	logic        max_ncs;
	logic        max_clk;
	step_t       steps [0:num_steps-1];
	int          model_col;
	logic [15:0] rdata;

	ledgame_top #(.debounce_cycles(debounce), .clk_div(2)) dut_i (
		.clock_50       (clock_50),
		.rst_n          (rst_n),
		.start_button_n (start_button_n),
		.left_button_n  (left_button_n),
		.right_button_n (right_button_n),
		.wb_cyc         (wb_cyc),
		.wb_stb         (wb_stb),
		.wb_we          (wb_we),
		.wb_adr         (wb_adr),
		.wb_dat_w       (wb_dat_w),
		.wb_dat_r       (wb_dat_r),
		.wb_ack         (wb_ack),
		.max_din        (max_din),
		.max_ncs        (max_ncs),
		.max_clk        (max_clk)
	);

	max7219_monitor mon_i (
		.max_din (max_din),
		.max_ncs (max_ncs),
		.max_clk (max_clk)
	);

	initial begin
		clock_50 = 1'b0;
		forever #50 clock_50 = ~clock_50;
	end

	//##########################################################################
	// Helpers
	//##########################################################################
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			report_failure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
				name, got, expected));
		end
	endtask

	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [15:0] wdat,
			output logic [15:0] rdat);
		int cycles;
		cycles = 0;
		@(posedge clock_50);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdat;
		do begin
			@(posedge clock_50);
			cycles++;
			if (cycles > 20) report_failure("no Wishbone ack within 20 cycles");
		end while (!wb_ack);
		rdat = wb_dat_r;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		// Ack lasts exactly one cycle
		@(posedge clock_50);
		check_value("wb_ack", wb_ack, 1'b0);
	endtask

	task automatic press_button(input action_t act);
		@(posedge clock_50);
		case (act)
			act_start: start_button_n <= 1'b0;
			act_left:  left_button_n <= 1'b0;
			default:   right_button_n <= 1'b0;
		endcase
		// Held through synchroniser and debounce then high long enough to re-arm
		repeat (debounce + 6) @(posedge clock_50);
		start_button_n <= 1'b1;
		left_button_n  <= 1'b1;
		right_button_n <= 1'b1;
		repeat (debounce + 6) @(posedge clock_50);
	endtask

	task automatic check_status(input logic [1:0] st, input logic [2:0] row,
			input logic [2:0] col);
		logic [15:0] status;
		bus_access(1'b0, 2'd2, 16'h0000, status);
		check_value("status.state", status[1:0], st);
		check_value("status.row", status[6:4], row);
		check_value("status.col", status[10:8], col);
	endtask

	// Second digit-8 word ends an image sampled wholly after the step
	task automatic check_images(input logic [1:0] st, input int row, input int col);
		logic [63:0] model;
		logic [7:0]  expected;
		int          start_count;
		int          cycles;
		start_count = mon_i.refresh_count;
		cycles      = 0;
		while (mon_i.refresh_count < start_count + 2) begin
			@(posedge clock_50);
			cycles++;
			if (cycles > 4000) report_failure("timeout waiting for a display refresh");
		end
		model        = '0;
		model[39:32] = 8'hCC;
		if (st != 2'd0) model[row * 8 + col] = 1'b1;
		for (int k = 1; k <= 8; k++) begin
			for (int r = 0; r < 8; r++) begin
				expected[7 - r] = model[r * 8 + 8 - k];
			end
			check_value($sformatf("digit%0d", k), mon_i.digits[k], expected);
		end
	endtask

	//##########################################################################
	// Stimulus
	//##########################################################################
	initial begin
		int n;
		int polls;
		n              = $urandom(32'hd64b4a1f);
		rst_n          = 1'b0;
		start_button_n = 1'b1;
		left_button_n  = 1'b1;
		right_button_n = 1'b1;
		wb_cyc         = 1'b0;
		wb_stb         = 1'b0;
		wb_we          = 1'b0;
		wb_adr         = 2'd0;
		wb_dat_w       = 16'h0000;
		steps[0] = '{act_write, 18'h1_FFFF, 2'd0, 3'd7, 3'd4};
		steps[1] = '{act_start, 18'd0, 2'd1, 3'd7, 3'd4};
		steps[2] = '{act_left, 18'd2, 2'd1, 3'd7, 3'd6};
		steps[3] = '{act_left, 18'd3, 2'd1, 3'd7, 3'd7};
		steps[4] = '{act_right, 18'd9, 2'd1, 3'd7, 3'd0};
		steps[5] = '{act_left, 18'd1, 2'd1, 3'd7, 3'd1};
		steps[6] = '{act_land, 18'd20, 2'd2, 3'd0, 3'd1};
		steps[7] = '{act_write, 18'h1_FFFF, 2'd2, 3'd0, 3'd1};
		steps[8] = '{act_start, 18'd0, 2'd1, 3'd7, 3'd4};
		repeat (8) @(posedge clock_50);
		rst_n <= 1'b1;

		// Init words after reset
		polls = 0;
		while (mon_i.word_count < 5) begin
			@(posedge clock_50);
			polls++;
			if (polls > 2000) report_failure("timeout waiting for the init words");
		end
		check_value("init_word0", mon_i.init_words[0], 16'h0C01);
		check_value("init_word1", mon_i.init_words[1], 16'h0B07);
		check_value("init_word2", mon_i.init_words[2], 16'h0900);
		check_value("init_word3", mon_i.init_words[3], 16'h0F00);
		check_value("init_word4", mon_i.init_words[4], 16'h0A0A);
		check_status(2'd0, 3'd7, 3'd4);

		// Intensity readback and on the serial line
		bus_access(1'b1, 2'd0, 16'h0003, rdata);
		bus_access(1'b0, 2'd0, 16'h0000, rdata);
		check_value("intensity", rdata, 16'h0003);
		n     = mon_i.intensity_count;
		polls = 0;
		while (mon_i.intensity_count < n + 2) begin
			@(posedge clock_50);
			polls++;
			if (polls > 3000) report_failure("timeout waiting for an intensity word");
		end
		check_value("intensity_word", mon_i.last_intensity, 8'h03);
		bus_access(1'b1, 2'd1, 16'h0000, rdata);
		bus_access(1'b0, 2'd1, 16'h0000, rdata);
		check_value("drop_period", rdata, 16'h0001);

		model_col = 4;
		for (int i = 0; i < num_steps; i++) begin
			case (steps[i].act)
				act_start: begin
					press_button(act_start);
					model_col = 4;
				end
				act_left, act_right: begin
					n = steps[i].arg;
					// Extra pushes against the edge the step ends on
					if ((steps[i].act == act_left && steps[i].col == 3'd7) ||
							(steps[i].act == act_right && steps[i].col == 3'd0)) begin
						n += $urandom_range(3, 0);
					end
					repeat (n) begin
						press_button(steps[i].act);
						if (steps[i].act == act_left) begin
							if (model_col < 7) model_col++;
						end else if (model_col > 0) begin
							model_col--;
						end
					end
				end
				act_write: bus_access(1'b1, steps[i].arg[17:16], steps[i].arg[15:0], rdata);
				default: begin
					bus_access(1'b1, 2'd1, steps[i].arg[15:0], rdata);
					polls = 0;
					do begin
						bus_access(1'b0, 2'd2, 16'h0000, rdata);
						polls++;
						if (polls > 200) report_failure("timeout waiting for the piece to land");
					end while (rdata[1:0] != 2'd2);
				end
			endcase
			check_status(steps[i].st, steps[i].row, steps[i].col);
			check_images(steps[i].st, steps[i].row, model_col);
		end
		check_value("bad_frames", mon_i.bad_frames, 0);

		$display("NO ERRORS");
		$finish;
	end

endmodule

/* testbench/max7219_monitor.sv */
/*
 * Passive MAX7219 decoder. Bits are taken on max_clk rising while max_ncs is
 * low, and a word is accepted when max_ncs rises after exactly 16 bits.
 */
`timescale 1ns/1ps

module max7219_monitor (
	input logic max_din,
	input logic max_ncs,
	input logic max_clk
);

	logic [15:0] shift_q;
	int          bit_count;
	logic [15:0] init_words [0:4];
	logic [7:0]  digits [1:8];
	logic [7:0]  last_intensity;
	int          word_count;
	int          intensity_count;
	int          refresh_count;
	int          bad_frames;

	initial begin
		shift_q         = '0;
		bit_count       = 0;
		last_intensity  = '0;
		word_count      = 0;
		intensity_count = 0;
		refresh_count   = 0;
		bad_frames      = 0;
		for (int k = 1; k <= 8; k++) begin
			digits[k] = '0;
		end
	end

	always @(posedge max_clk) begin
		if (max_ncs === 1'b0) begin
			shift_q   = {shift_q[14:0], max_din};
			bit_count = bit_count + 1;
		end
	end

	always @(posedge max_ncs) begin
		if (bit_count == 16) begin
			if (word_count < 5) begin
				init_words[word_count] = shift_q;
			end
			word_count = word_count + 1;
			if (shift_q[15:8] == 8'h0A) begin
				last_intensity  = shift_q[7:0];
				intensity_count = intensity_count + 1;
			end else if (shift_q[15:8] >= 8'd1 && shift_q[15:8] <= 8'd8) begin
				digits[shift_q[15:8]] = shift_q[7:0];
				// Digit 8 closes one full image
				if (shift_q[15:8] == 8'd8) begin
					refresh_count = refresh_count + 1;
				end
			end
		end else if (bit_count != 0) begin
			bad_frames = bad_frames + 1;
		end
		bit_count = 0;
	end

endmodule

/* verilog/ledgame_top.sv */
/*
 * Falling-piece game on an 8x8 matrix through a MAX7219.
 * Buttons are active low and asynchronous to clock_50.
 */
`timescale 1ns/1ps

module ledgame_top import ledgame_pkg::*; #(
	parameter int      debounce_cycles = 1000,
	parameter int      clk_div         = 4,
	parameter period_t default_period  = 16'd50000
) (
	input  logic        clock_50,
	input  logic        rst_n,
	input  logic        start_button_n,
	input  logic        left_button_n,
	input  logic        right_button_n,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [15:0] wb_dat_w,
	output logic [15:0] wb_dat_r,
	output logic        wb_ack,
	output logic        max_din,
	output logic        max_ncs,
	output logic        max_clk
);

	logic        start_press;
	logic        left_press;
	logic        right_press;
	intensity_t  intensity;
	period_t     drop_period;
	field_t      field;
	game_state_t state;
	row_idx_t    piece_row;
	row_idx_t    piece_col;

	//##########################################################################
	// Buttons
	//##########################################################################
	button_debounce #(.debounce_cycles(debounce_cycles)) start_db_i (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button_n (start_button_n),
		.press    (start_press)
	);

	button_debounce #(.debounce_cycles(debounce_cycles)) left_db_i (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button_n (left_button_n),
		.press    (left_press)
	);

	button_debounce #(.debounce_cycles(debounce_cycles)) right_db_i (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button_n (right_button_n),
		.press    (right_press)
	);

	//##########################################################################
	// Configuration and game
	//##########################################################################
	game_cfg_regs #(.default_period(default_period)) cfg_i (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.state       (state),
		.piece_row   (piece_row),
		.piece_col   (piece_col),
		.intensity   (intensity),
		.drop_period (drop_period)
	);

	piece_field game_i (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.start_press (start_press),
		.left_press  (left_press),
		.right_press (right_press),
		.drop_period (drop_period),
		.field       (field),
		.state       (state),
		.piece_row   (piece_row),
		.piece_col   (piece_col)
	);

	// Display side
	max7219_driver #(.clk_div(clk_div)) driver_i (
		.clock_50  (clock_50),
		.rst_n     (rst_n),
		.field     (field),
		.intensity (intensity),
		.max_din   (max_din),
		.max_ncs   (max_ncs),
		.max_clk   (max_clk)
	);

endmodule

/* verilog/max7219_driver.sv */
/*
 * MAX7219 serial driver that sends five init words and then loops over digits 1..8 and intensity.
 * max_clk half period is clk_div clocks and data changes while max_clk is low.
 */
`timescale 1ns/1ps

module max7219_driver import ledgame_pkg::*; #(
	parameter int clk_div = 4
) (
	input  logic       clock_50,
	input  logic       rst_n,
	input  field_t     field,
	input  intensity_t intensity,
	output logic       max_din,
	output logic       max_ncs,
	output logic       max_clk
);

	localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;

	typedef enum logic {
		drv_gap,
		drv_shift
	} drv_state_t;

	drv_state_t       drv_state;
	logic [div_w-1:0] div_cnt;
	logic             tick;
	logic             gap_half;
	logic [3:0]       bit_cnt;
	logic [3:0]       seq_idx;
	logic [3:0]       digit_k;
	row_idx_t         digit_col;
	max_word_t        next_word;
	max_word_t        shift_q;
	logic             load;
	logic             shift;

	// Digit data is one column with row 0 in the MSB
	function automatic row_t column_of(field_t f, row_idx_t col);
		row_t d;
		for (int r = 0; r < 8; r++) begin
			d[7 - r] = f[r * 8 + int'(col)];
		end
		return d;
	endfunction

	//##########################################################################
	// Word sequence
	//##########################################################################
	// seq_idx 0..4 init, 5..12 digits 1..8, 13 intensity
	assign digit_k   = seq_idx - 4'd4;
	assign digit_col = row_idx_t'(4'd12 - seq_idx);

	always_comb begin
		case (seq_idx)
			4'd0:        next_word = {max_addr_shutdown, 8'h01};
			4'd1:        next_word = {max_addr_scan_limit, 8'h07};
			4'd2:        next_word = {max_addr_decode, 8'h00};
			4'd3:        next_word = {max_addr_display_test, 8'h00};
			4'd4, 4'd13: next_word = {max_addr_intensity, 4'h0, intensity};
			default:     next_word = {4'h0, digit_k, column_of(field, digit_col)};
		endcase
	end

	//##########################################################################
	// Serial timing
	//##########################################################################
	assign tick  = (div_cnt == div_w'(clk_div - 1));
	assign load  = tick && (drv_state == drv_gap) && gap_half;
	assign shift = tick && (drv_state == drv_shift) && max_clk && (bit_cnt != 4'd0);

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			drv_state <= drv_gap;
			div_cnt   <= '0;
			gap_half  <= 1'b0;
			bit_cnt   <= 4'd0;
			seq_idx   <= 4'd0;
			max_ncs   <= 1'b1;
			max_clk   <= 1'b0;
			max_din   <= 1'b0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				case (drv_state)
					drv_gap: begin
						gap_half <= !gap_half;
						if (gap_half) begin
							// Field is sampled at the start of a frame
							max_ncs   <= 1'b0;
							max_din   <= next_word[15];
							bit_cnt   <= 4'd15;
							seq_idx   <= (seq_idx == 4'd13) ? 4'd5 : seq_idx + 4'd1;
							drv_state <= drv_shift;
						end
					end
					drv_shift: begin
						max_clk <= !max_clk;
						if (max_clk) begin
							if (bit_cnt == 4'd0) begin
								// Rising ncs latches the word
								max_ncs   <= 1'b1;
								max_din   <= 1'b0;
								drv_state <= drv_gap;
							end else begin
								max_din <= shift_q[15];
								bit_cnt <= bit_cnt - 4'd1;
							end
						end
					end
					default: drv_state <= drv_gap;
				endcase
			end
		end
	end

	// Remaining bits with the MSB next
	always_ff @(posedge clock_50) begin
		if (load) begin
			shift_q <= {next_word[14:0], 1'b0};
		end else if (shift) begin
			shift_q <= {shift_q[14:0], 1'b0};
		end
	end

endmodule

/* verilog/piece_field.sv */
/*
 * One-pixel falling piece. Start restarts from any state; left and right
 * are ignored outside falling. Field is the background OR the piece bit.
 */
`timescale 1ns/1ps

module piece_field import ledgame_pkg::*; (
	input  logic        clock_50,
	input  logic        rst_n,
	input  logic        start_press,
	input  logic        left_press,
	input  logic        right_press,
	input  period_t     drop_period,
	output field_t      field,
	output game_state_t state,
	output row_idx_t    piece_row,
	output row_idx_t    piece_col
);

	period_t timer;
	logic    drop_tick;

	// Timer runs 1 .. drop_period with one tick per period
	assign drop_tick = (state == game_falling) && (timer >= drop_period);

	//##########################################################################
	// Game FSM and piece position
	//##########################################################################
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			state     <= game_idle;
			piece_row <= 3'd7;
			piece_col <= piece_start_col;
			timer     <= period_t'(1);
		end else if (start_press) begin
			state     <= game_falling;
			piece_row <= 3'd7;
			piece_col <= piece_start_col;
			timer     <= period_t'(1);
		end else if (state == game_falling) begin
			// Left has priority if both arrive together
			if (left_press && piece_col != 3'd7) begin
				piece_col <= piece_col + 3'd1;
			end else if (right_press && piece_col != 3'd0) begin
				piece_col <= piece_col - 3'd1;
			end

			if (drop_tick) begin
				timer <= period_t'(1);
				if (piece_row == 3'd0) begin
					state <= game_landed;
				end else begin
					piece_row <= piece_row - 3'd1;
				end
			end else begin
				timer <= timer + period_t'(1);
			end
		end
	end

	//##########################################################################
	// Displayed field
	//##########################################################################
	always_comb begin
		field = background_field;
		// Bit index is row*8 + column
		if (state != game_idle) begin
			field[{piece_row, piece_col}] = 1'b1;
		end
	end

endmodule

/* verilog/game_cfg_regs.sv */
/*
 * Wishbone classic slave that acks one cycle after a request and never twice in a row.
 * Address 0 intensity, 1 drop period (0 stored as 1), 2 read-only status.
 */
`timescale 1ns/1ps

module game_cfg_regs import ledgame_pkg::*; #(
	parameter period_t default_period = 16'd50000
) (
	input  logic        clock_50,
	input  logic        rst_n,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [15:0] wb_dat_w,
	output logic [15:0] wb_dat_r,
	output logic        wb_ack,
	input  game_state_t state,
	input  row_idx_t    piece_row,
	input  row_idx_t    piece_col,
	output intensity_t  intensity,
	output period_t     drop_period
);

	logic req;

	// New request only while no ack is pending
	assign req = wb_cyc && wb_stb && !wb_ack;

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack      <= 1'b0;
			intensity   <= 4'hA;
			drop_period <= default_period;
		end else begin
			wb_ack <= req;
			if (req && wb_we) begin
				case (wb_adr)
					2'd0: intensity <= wb_dat_w[3:0];
					2'd1: drop_period <= (wb_dat_w == '0) ? period_t'(1) : wb_dat_w;
					default: ;
				endcase
			end
		end
	end

	// Master holds wb_adr, so data stays valid through the ack cycle
	always_comb begin
		case (wb_adr)
			2'd0:    wb_dat_r = {12'h000, intensity};
			2'd1:    wb_dat_r = drop_period;
			2'd2:    wb_dat_r = {5'd0, piece_col, 1'b0, piece_row, 2'b00, state};
			default: wb_dat_r = '0;
		endcase
	end

endmodule

/* verilog/button_debounce.sv */
/*
 * Active-low button in, one press pulse out, debounce_cycles + 2 clocks
 * after the pin settles low. The pin must stay high debounce_cycles to re-arm.
 */
`timescale 1ns/1ps

module button_debounce #(
	parameter int debounce_cycles = 1000
) (
	input  logic clock_50,
	input  logic rst_n,
	input  logic button_n,
	output logic press
);

	localparam int cnt_w = $clog2(debounce_cycles) + 1;

	logic [1:0]       sync_q;
	logic             stable;
	logic [cnt_w-1:0] count;

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= 2'b11;
			stable <= 1'b1;
			count  <= '0;
			press  <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], button_n};
			press  <= 1'b0;
			if (sync_q[1] == stable) begin
				count <= '0;
			end else if (count == cnt_w'(debounce_cycles - 1)) begin
				// Level held long enough to be accepted
				stable <= sync_q[1];
				count  <= '0;
				press  <= stable;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

/* verilog/ledgame_pkg.sv */
/*
 * Types and constants for the LED matrix game. Row 7 is the top row and
 * bit 7 of a row is the leftmost column. The background pattern is fixed.
 */
package ledgame_pkg;

	typedef logic [7:0]  row_t;
	typedef logic [63:0] field_t;
	typedef logic [2:0]  row_idx_t;
	typedef logic [3:0]  intensity_t;
	typedef logic [15:0] period_t;
	typedef logic [15:0] max_word_t;

	// Encoding is visible in status register bits 1:0
	typedef enum logic [1:0] {
		game_idle    = 2'd0,
		game_falling = 2'd1,
		game_landed  = 2'd2
	} game_state_t;

	// Row r lives in bits r*8+7 .. r*8 and only row 4 is lit
	localparam field_t background_field = 64'h0000_00CC_0000_0000;

	localparam row_idx_t piece_start_col = 3'd4;

	// MAX7219 control register addresses
	// Digit k uses address k
	localparam logic [7:0] max_addr_decode       = 8'h09;
	localparam logic [7:0] max_addr_intensity    = 8'h0A;
	localparam logic [7:0] max_addr_scan_limit   = 8'h0B;
	localparam logic [7:0] max_addr_shutdown     = 8'h0C;
	localparam logic [7:0] max_addr_display_test = 8'h0F;

endpackage
